// File: Makefile
# Verilator build and run of the texture cache testbench

VERILATOR ?= verilator
TOP       ?= tb_tex_cache
FILELIST  ?= tex_cache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) tex_cache_defines.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@grep -qx 'test passed' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_tex_cache.sv
/* testbench for the texture cache data store: file-driven requests,
   random result back-pressure, in-order pixel scoreboard and watchdog */
`timescale 1ns/1ns
`include "tex_cache_defines.svh"

module tb_tex_cache
	import tex_pix_pkg::*, tex_ctl_pkg::*;
();

	logic      clk;
	logic      reset;
	logic      endian;
	tex_op_e   s_op;
	tag_t      s_tag;
	pix_addr_t s_pix_addr;
	word_t     s_wdata;
	logic      s_range_out;
	logic      s_valid;
	logic      s_ready;
	pix_t      m_data;
	logic      m_valid;
	logic      m_ready;

	// test lines from the data file
	string     t_name [$];
	tex_op_e   t_op [$];
	tag_t      t_tag [$];
	pix_addr_t t_addr [$];
	word_t     t_wdata [$];
	logic      t_range [$];
	logic      t_endian [$];
	pix_t      t_exp [$];
	int        num_tests;

	// reads accepted but not returned yet
	pix_t      exp_q [$];
	string     exp_name_q [$];

	logic [31:0] rnd;

	tex_cache_top dut_i (.*);

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	function automatic logic [31:0] next_random(logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic load_tests();
		int fd;
		int n;
		string line;
		string name;
		logic [3:0] op;
		tag_t tag;
		pix_addr_t addr;
		word_t wdata;
		logic rng;
		logic en;
		pix_t expected;
		fd = $fopen("tex_cache_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open tex_cache_tests.txt");
			$display("test failed");
			$fatal(1, "no test data");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				n = $sscanf(line, "%s %h %h %h %h %h %h %h",
					name, op, tag, addr, wdata, rng, en, expected);
				// comment and blank lines do not parse to eight fields
				if (n == 8 && line[0] != "#") begin
					t_name.push_back(name);
					t_op.push_back(tex_op_e'(op[0]));
					t_tag.push_back(tag);
					t_addr.push_back(addr);
					t_wdata.push_back(wdata);
					t_range.push_back(rng);
					t_endian.push_back(en);
					t_exp.push_back(expected);
				end
			end
			$fclose(fd);
			num_tests = t_name.size();
		end
	endtask

	task automatic check_pix(string name, pix_t expected, pix_t actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1, "pixel mismatch");
		end
	endtask

	// all accepted reads returned
	task automatic wait_reads_done();
		@(negedge clk);
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	// ----------------------------------------
	// clock, back-pressure, scoreboard
	// ----------------------------------------

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		rnd = 32'h87dd_fb93;
		m_ready <= 1'b0;
		forever begin
			@(posedge clk);
			rnd = next_random(rnd);
			m_ready <= (rnd[31:30] != 2'b00);
		end
	end

	always @(posedge clk) begin
		if (!reset && m_valid && m_ready) begin
			if (exp_q.size() == 0) begin
				$display("result %h arrived with no read outstanding", m_data);
				$display("test failed");
				$fatal(1, "extra result");
			end else begin
				check_pix(exp_name_q.pop_front(), exp_q.pop_front(), m_data);
			end
		end
	end

	initial begin
		@(negedge clk);
		repeat (60 * num_tests + 40) @(posedge clk);
		$display("timeout with %0d reads still outstanding", exp_q.size());
		$display("test failed");
		$fatal(1, "watchdog");
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	initial begin
		reset <= 1'b1;
		endian <= 1'b0;
		s_valid <= 1'b0;
		s_op <= OP_WRITE;
		s_tag <= '0;
		s_pix_addr <= '0;
		s_wdata <= '0;
		s_range_out <= 1'b0;
		load_tests();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < num_tests; i++) begin
			// endian only changes with no read in flight
			if (t_endian[i] != endian) begin
				s_valid <= 1'b0;
				wait_reads_done();
				endian <= t_endian[i];
			end
			s_valid <= 1'b1;
			s_op <= t_op[i];
			s_tag <= t_tag[i];
			s_pix_addr <= t_addr[i];
			s_wdata <= t_wdata[i];
			s_range_out <= t_range[i];
			@(posedge clk);
			while (!s_ready) begin
				@(posedge clk);
			end
			if (t_op[i] == OP_READ) begin
				exp_q.push_back(t_exp[i]);
				exp_name_q.push_back(t_name[i]);
			end
		end
		s_valid <= 1'b0;
		wait_reads_done();
		// quiet tail where any late result trips the scoreboard
		repeat (20) @(posedge clk);
		$display("test passed");
		$finish;
	end

endmodule

// File: tex_bank_dispatch.sv
/* request dispatcher: bank decode from the tag, input handshake
   and order queue push */
`timescale 1ns/1ns
`include "tex_cache_defines.svh"

module tex_bank_dispatch
	import tex_pix_pkg::*, tex_ctl_pkg::*;
(
	input  logic      clk,
	input  logic      reset,

	input  tex_op_e   s_op,
	input  tag_t      s_tag,
	input  pix_addr_t s_pix_addr,
	input  word_t     s_wdata,
	input  logic      s_range_out,
	input  logic      s_valid,
	output logic      s_ready,

	tex_req_if.dispatch banks [`TEX_NUM_BANKS],

	output logic      ord_push,
	output bank_t     ord_bank,
	output logic      ord_read,
	input  logic      ord_full
);

	bank_t sel_bank;
	logic run;
	logic open;
	logic [`TEX_NUM_BANKS-1:0] bank_ready;
	logic [`TEX_NUM_BANKS-1:0] bank_take;

	// ----------------------------------------
	// bank decode and gating
	// ----------------------------------------

	assign sel_bank = s_tag[`TEX_BANK_BITS-1:0];

	// input stays closed until the cycle after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
		end else begin
			run <= 1'b1;
		end
	end

	assign open = run && !ord_full;
	assign s_ready = open && bank_ready[sel_bank];

	// payload goes to every bank, valid only to the selected one
	for (genvar i = 0; i < `TEX_NUM_BANKS; i++) begin : g_bank
		assign banks[i].valid     = s_valid && open && (sel_bank == bank_t'(i));
		assign banks[i].op        = s_op;
		assign banks[i].tag       = s_tag;
		assign banks[i].pix_addr  = s_pix_addr;
		assign banks[i].wdata     = s_wdata;
		assign banks[i].range_out = s_range_out;
		assign bank_ready[i] = banks[i].ready;
		assign bank_take[i]  = banks[i].valid && banks[i].ready;
	end

	// ----------------------------------------
	// order queue push
	// ----------------------------------------

	assign ord_push = s_valid && s_ready;
	assign ord_bank = sel_bank;
	assign ord_read = (s_op == OP_READ);

	// every push matches exactly one bank taking the request
	a_push_one_bank: assert property (@(posedge clk) disable iff (reset)
		ord_push |-> !ord_full && $onehot(bank_take));

endmodule

// File: tex_bank_merge.sv
/* order queue and result multiplexer: returns read results in
   request order and drops write results */
`timescale 1ns/1ns
`include "tex_cache_defines.svh"

module tex_bank_merge
	import tex_pix_pkg::*, tex_ctl_pkg::*;
(
	input  logic clk,
	input  logic reset,

	input  pix_t rsp_data [`TEX_NUM_BANKS],
	input  logic [`TEX_NUM_BANKS-1:0] rsp_valid,
	output logic [`TEX_NUM_BANKS-1:0] rsp_ready,

	input  logic  ord_push,
	input  bank_t ord_bank,
	input  logic  ord_read,
	output logic  ord_full,

	output pix_t m_data,
	output logic m_valid,
	input  logic m_ready
);

	localparam int PTR_BITS = $clog2(`TEX_ORDER_DEPTH);

	bank_t q_bank [`TEX_ORDER_DEPTH];
	logic  q_read [`TEX_ORDER_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0] count;

	logic empty;
	bank_t head_bank;
	logic head_read;
	logic head_valid;
	logic take;
	logic pop;

	// ----------------------------------------
	// order queue
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (ord_push) begin
			q_bank[wr_ptr] <= ord_bank;
			q_read[wr_ptr] <= ord_read;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (ord_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({ord_push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign empty = (count == '0);
	assign ord_full = (count == (PTR_BITS + 1)'(`TEX_ORDER_DEPTH));

	// ----------------------------------------
	// head bank select
	// ----------------------------------------

	assign head_bank = q_bank[rd_ptr];
	assign head_read = q_read[rd_ptr];
	assign head_valid = !empty && rsp_valid[head_bank];

	// write results are taken without waiting for m_ready
	assign take = !empty && (m_ready || !head_read);
	assign pop = head_valid && take;

	always_comb begin
		rsp_ready = '0;
		rsp_ready[head_bank] = take;
	end

	assign m_data = rsp_data[head_bank];
	assign m_valid = head_valid && head_read;

	// a bank result always has its queue entry, so pops never see an empty queue
	a_no_orphan: assert property (@(posedge clk) disable iff (reset)
		empty |-> rsp_valid == '0);

	a_head_only: assert property (@(posedge clk) disable iff (reset)
		|(rsp_valid & rsp_ready) |->
			(rsp_valid & rsp_ready) == (`TEX_NUM_BANKS'(1) << head_bank));

endmodule

// File: tex_cache.f
+incdir+.
tex_pix_pkg.sv
tex_ctl_pkg.sv
tex_req_if.sv
tex_bank_dispatch.sv
tex_cache_mem.sv
tex_bank_merge.sv
tex_cache_top.sv
tb_tex_cache.sv

// File: tex_cache_defines.svh
/* size macros for the texture cache data store:
   banks, tags, pixel addressing, pixel width and order queue depth */
`ifndef TEX_CACHE_DEFINES_SVH
`define TEX_CACHE_DEFINES_SVH

// ----------------------------------------
// banking
// ----------------------------------------
`define TEX_NUM_BANKS 4
`define TEX_BANK_BITS 2

// ----------------------------------------
// line and pixel addressing
// ----------------------------------------
// low TEX_BANK_BITS of the tag pick the bank
`define TEX_TAG_BITS 6
`define TEX_PIX_ADDR_BITS 4
// log2 of pixels per ram word
`define TEX_WIDE_SIZE 1

`define TEX_PIX_BITS 24
`define TEX_BORDER_PIX {`TEX_PIX_BITS{1'b0}}

// requests in flight over all banks
`define TEX_ORDER_DEPTH 16

`endif

// File: tex_cache_mem.sv
/* one cache memory bank: intake register, single-port ram,
   pixel select and border substitution in a four-stage pipeline */
`timescale 1ns/1ns
`include "tex_cache_defines.svh"

module tex_cache_mem
	import tex_pix_pkg::*, tex_ctl_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic endian,

	tex_req_if.bank req,

	output pix_t rsp_data,
	output logic rsp_valid,
	input  logic rsp_ready
);

	localparam int SEL_BITS      = `TEX_WIDE_SIZE;
	localparam int LINE_BITS     = `TEX_TAG_BITS - `TEX_BANK_BITS;
	localparam int WORD_BITS     = `TEX_PIX_ADDR_BITS - `TEX_WIDE_SIZE;
	localparam int RAM_ADDR_BITS = LINE_BITS + WORD_BITS;
	localparam int RAM_WORDS     = 1 << RAM_ADDR_BITS;

	logic advance;

	// intake register
	logic      in_valid;
	tex_op_e   in_op;
	tag_t      in_tag;
	pix_addr_t in_pix_addr;
	word_t     in_wdata;
	logic      in_range_out;

	logic [3:0] stage_valid;

	logic [WORD_BITS-1:0] word_addr;
	logic [RAM_ADDR_BITS-1:0] ram_addr;
	word_t ram [RAM_WORDS];

	word_t st0_word;
	logic [SEL_BITS-1:0] st0_sel;
	logic st0_range_out;

	word_t st1_word;
	logic [SEL_BITS-1:0] st1_sel;
	logic st1_range_out;

	logic [SEL_BITS-1:0] sel_idx;
	pix_t sel_pix;
	pix_t st2_pix;
	logic st2_range_out;

	pix_t st3_pix;

	// ----------------------------------------
	// pipeline control
	// ----------------------------------------

	// whole pipe freezes while the output is held
	assign advance = !(stage_valid[3] && !rsp_ready);
	assign req.ready = advance;

	always_ff @(posedge clk) begin
		if (reset) begin
			in_valid <= 1'b0;
			stage_valid <= '0;
		end else if (advance) begin
			in_valid <= req.valid;
			stage_valid <= {stage_valid[2:0], in_valid};
		end
	end

	always_ff @(posedge clk) begin
		if (advance && req.valid) begin
			in_op <= req.op;
			in_tag <= req.tag;
			in_pix_addr <= req.pix_addr;
			in_wdata <= req.wdata;
			in_range_out <= req.range_out;
		end
	end

	// ----------------------------------------
	// stage 0: ram access
	// ----------------------------------------

	assign word_addr = WORD_BITS'(in_pix_addr >> `TEX_WIDE_SIZE);
	assign ram_addr = {in_tag[`TEX_TAG_BITS-1:`TEX_BANK_BITS], word_addr};

	// read returns the old word on a write
	always_ff @(posedge clk) begin
		if (advance) begin
			if (in_valid && in_op == OP_WRITE) begin
				ram[ram_addr] <= in_wdata;
			end
			st0_word <= ram[ram_addr];
			st0_sel <= in_pix_addr[SEL_BITS-1:0];
			st0_range_out <= in_range_out;
		end
	end

	// ----------------------------------------
	// stages 1 to 3
	// ----------------------------------------

	// endian high puts pixel 0 in the upper half
	assign sel_idx = st1_sel ^ {SEL_BITS{endian}};
	assign sel_pix = st1_word[sel_idx * `TEX_PIX_BITS +: `TEX_PIX_BITS];

	always_ff @(posedge clk) begin
		if (advance) begin
			st1_word <= st0_word;
			st1_sel <= st0_sel;
			st1_range_out <= st0_range_out;
			st2_pix <= sel_pix;
			st2_range_out <= st1_range_out;
			st3_pix <= st2_range_out ? `TEX_BORDER_PIX : st2_pix;
		end
	end

	assign rsp_data = st3_pix;
	assign rsp_valid = stage_valid[3];

	// a held result must not change until the merge takes it
	a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

// File: tex_cache_tests.txt
# name op tag pix_addr wdata range_out endian expected, all hex
# op 0 writes a two-pixel word, op 1 reads one pixel
wr_b0 0 00 0 111111aaaaaa 0 0 000000
wr_b1 0 05 2 222222bbbbbb 0 0 000000
wr_b2 0 0a 4 333333cccccc 0 0 000000
wr_b3 0 0f e 444444dddddd 0 0 000000
wr_b1_far 0 21 6 555555eeeeee 0 0 000000
wr_b2_far 0 3e 8 666666123456 0 0 000000
rd_b0_even 1 00 0 000000000000 0 0 aaaaaa
rd_b0_odd 1 00 1 000000000000 0 0 111111
rd_b1_even 1 05 2 000000000000 0 0 bbbbbb
rd_b1_odd 1 05 3 000000000000 0 0 222222
rd_b2_even 1 0a 4 000000000000 0 0 cccccc
rd_b2_odd 1 0a 5 000000000000 0 0 333333
rd_b3_even 1 0f e 000000000000 0 0 dddddd
rd_b3_odd 1 0f f 000000000000 0 0 444444
rd_b1_far_even 1 21 6 000000000000 0 0 eeeeee
rd_b1_far_odd 1 21 7 000000000000 0 0 555555
rd_b2_far_even 1 3e 8 000000000000 0 0 123456
rd_border 1 05 2 000000000000 1 0 000000
rd_il_b3 1 0f e 000000000000 0 0 dddddd
rd_il_b0 1 00 1 000000000000 0 0 111111
rd_il_b2 1 3e 9 000000000000 0 0 666666
rd_il_b1 1 21 6 000000000000 0 0 eeeeee
rd_il_b0_even 1 00 0 000000000000 0 0 aaaaaa
rd_e1_b0_even 1 00 0 000000000000 0 1 111111
rd_e1_b0_odd 1 00 1 000000000000 0 1 aaaaaa
rd_e1_b3_even 1 0f e 000000000000 0 1 444444
rd_e1_b1_odd 1 21 7 000000000000 0 1 eeeeee
rd_e1_border 1 0a 4 000000000000 1 1 000000
wr_b0_new 0 00 0 777777999999 0 1 000000
rd_e1_b0_new 1 00 0 000000000000 0 1 777777
rd_e0_b0_new 1 00 0 000000000000 0 0 999999
rd_e0_b2_odd 1 0a 5 000000000000 0 0 333333

// File: tex_cache_top.sv
/* texture cache data store top: dispatcher, four banks
   and the in-order result merge */
`timescale 1ns/1ns
`include "tex_cache_defines.svh"

module tex_cache_top
	import tex_pix_pkg::*, tex_ctl_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      endian,

	input  tex_op_e   s_op,
	input  tag_t      s_tag,
	input  pix_addr_t s_pix_addr,
	input  word_t     s_wdata,
	input  logic      s_range_out,
	input  logic      s_valid,
	output logic      s_ready,

	output pix_t      m_data,
	output logic      m_valid,
	input  logic      m_ready
);

	tex_req_if req_if [`TEX_NUM_BANKS] ();

	pix_t rsp_data [`TEX_NUM_BANKS];
	logic [`TEX_NUM_BANKS-1:0] rsp_valid;
	logic [`TEX_NUM_BANKS-1:0] rsp_ready;

	logic  ord_push;
	bank_t ord_bank;
	logic  ord_read;
	logic  ord_full;

	// ----------------------------------------
	// request side
	// ----------------------------------------

	tex_bank_dispatch dispatch_i (
		.clk        (clk),
		.reset      (reset),
		.s_op       (s_op),
		.s_tag      (s_tag),
		.s_pix_addr (s_pix_addr),
		.s_wdata    (s_wdata),
		.s_range_out(s_range_out),
		.s_valid    (s_valid),
		.s_ready    (s_ready),
		.banks      (req_if),
		.ord_push   (ord_push),
		.ord_bank   (ord_bank),
		.ord_read   (ord_read),
		.ord_full   (ord_full)
	);

	// ----------------------------------------
	// banks
	// ----------------------------------------

	for (genvar i = 0; i < `TEX_NUM_BANKS; i++) begin : g_bank
		tex_cache_mem mem_i (
			.clk      (clk),
			.reset    (reset),
			.endian   (endian),
			.req      (req_if[i]),
			.rsp_data (rsp_data[i]),
			.rsp_valid(rsp_valid[i]),
			.rsp_ready(rsp_ready[i])
		);
	end

	// results back in request order
	tex_bank_merge merge_i (
		.clk      (clk),
		.reset    (reset),
		.rsp_data (rsp_data),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.ord_push (ord_push),
		.ord_bank (ord_bank),
		.ord_read (ord_read),
		.ord_full (ord_full),
		.m_data   (m_data),
		.m_valid  (m_valid),
		.m_ready  (m_ready)
	);

endmodule

// File: tex_ctl_pkg.sv
/* request opcode and bank index type */
`include "tex_cache_defines.svh"

package tex_ctl_pkg;

	// ----------------------------------------
	// request control
	// ----------------------------------------

	// a write stores a whole word, a read returns one pixel
	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} tex_op_e;

	// which cache bank a tag lands in
	typedef logic [`TEX_BANK_BITS-1:0] bank_t;

endpackage

// File: tex_pix_pkg.sv
/* data types for pixels, wide ram words, line tags
   and pixel addresses */
`include "tex_cache_defines.svh"

package tex_pix_pkg;

	// ----------------------------------------
	// pixel data
	// ----------------------------------------

	// one texel
	typedef logic [`TEX_PIX_BITS-1:0] pix_t;

	// two pixels per ram word, pixel 0 in the low half
	typedef logic [(`TEX_PIX_BITS << `TEX_WIDE_SIZE)-1:0] word_t;

	// ----------------------------------------
	// addressing
	// ----------------------------------------

	typedef logic [`TEX_TAG_BITS-1:0] tag_t;

	// pixel within a line
	typedef logic [`TEX_PIX_ADDR_BITS-1:0] pix_addr_t;

endpackage

// File: tex_req_if.sv
/* request path from the dispatcher to one cache bank */
`timescale 1ns/1ns

interface tex_req_if
	import tex_pix_pkg::*, tex_ctl_pkg::*;
();

	// handshake
	logic      valid;
	logic      ready;

	// payload
	tex_op_e   op;
	tag_t      tag;
	pix_addr_t pix_addr;
	word_t     wdata;
	logic      range_out;

	modport dispatch (
		output valid, op, tag, pix_addr, wdata, range_out,
		input  ready
	);

	modport bank (
		input  valid, op, tag, pix_addr, wdata, range_out,
		output ready
	);

endinterface
